/* common/rv32_pkg.sv */
package rv32_pkg;

    localparam int XLEN = 32;

    // ========================================
    // memory operation codes
    // ========================================

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_t;

    // ========================================
    // stage records
    // ========================================

    // record handed over by execute.
    typedef struct packed {
        logic [XLEN-1:0] mem_addr;
        mem_op_t         mem_op;
        logic [XLEN-1:0] wb_result;
        logic [4:0]      rd;
    } exec_buffer_data_t;

    // addr is word aligned, data already sits in its byte lanes.
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic            write;
        logic [3:0]      strobe;
        logic [XLEN-1:0] data;
    } memory_request_t;

    typedef struct packed {
        logic [XLEN-1:0] data;
    } memory_response_t;

    // data is zero for stores and for misaligned accesses.
    typedef struct packed {
        logic [XLEN-1:0] data;
        logic [4:0]      rd;
        logic            is_load;
        logic            misaligned;
    } writeback_t;

    function automatic logic is_load_op(mem_op_t op);
        return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    endfunction

    function automatic logic is_store_op(mem_op_t op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

endpackage

/* load_store/rv32_load_extend.sv */
`timescale 1ns/1ps

module rv32_load_extend (
    input  rv32_pkg::mem_op_t mem_op,
    input  logic [1:0]        byte_offset,
    input  logic [31:0]       word,
    output logic [31:0]       data
);

    import rv32_pkg::*;

    logic [15:0] lane;

    // shift the addressed byte or half down to bit 0.
    // half loads only see offset 0 or 2 here.
    assign lane = 16'(word >> {byte_offset, 3'b000});

    // ========================================
    // sign and zero extension
    // ========================================

    always_comb begin
        case (mem_op)
            MEM_LB: begin
                data = {{24{lane[7]}}, lane[7:0]};
            end
            MEM_LBU: begin
                data = {24'b0, lane[7:0]};
            end
            MEM_LH: begin
                data = {{16{lane[15]}}, lane[15:0]};
            end
            MEM_LHU: begin
                data = {16'b0, lane[15:0]};
            end
            MEM_LW: begin
                data = word;
            end
            // stores and empty ops write back zero.
            default: begin
                data = '0;
            end
        endcase
    end

endmodule

/* load_store/rv32_load_store_unit.sv */
`timescale 1ns/1ps

module rv32_load_store_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        exec_valid,
    output logic                        exec_ready,
    input  rv32_pkg::exec_buffer_data_t exec_data,
    output logic                        req_valid,
    input  logic                        req_ready,
    output rv32_pkg::memory_request_t   data_request,
    input  logic                        resp_valid,
    input  rv32_pkg::memory_response_t  data_response,
    output logic                        wb_valid,
    input  logic                        wb_ready,
    output rv32_pkg::writeback_t        wb_data
);

    import rv32_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_HOLD
    } state_t;

    state_t          state;
    logic [1:0]      offset;
    logic            misaligned;
    logic            go_memory;
    logic            take;
    logic [1:0]      op_offset;
    mem_op_t         op_code;
    logic [4:0]      op_rd;
    logic [XLEN-1:0] load_data;
    writeback_t      reply_rec;
    writeback_t      held_rec;

    assign offset = exec_data.mem_addr[1:0];

    // halves need an even address, words need offset zero.
    always_comb begin
        case (exec_data.mem_op)
            MEM_LH, MEM_LHU, MEM_SH: misaligned = offset[0];
            MEM_LW, MEM_SW:          misaligned = (offset != 2'b00);
            default:                 misaligned = 1'b0;
        endcase
    end

    assign go_memory = (is_load_op(exec_data.mem_op) || is_store_op(exec_data.mem_op))
                       && !misaligned;

    assign exec_ready = (state == ST_IDLE) && req_ready;
    assign take       = exec_valid && exec_ready;
    assign req_valid  = (state == ST_IDLE) && exec_valid && go_memory;

    // ========================================
    // request with lane placement
    // ========================================

    always_comb begin
        data_request.addr  = {exec_data.mem_addr[XLEN-1:2], 2'b00};
        data_request.write = is_store_op(exec_data.mem_op);
        case (exec_data.mem_op)
            MEM_SB: begin
                data_request.strobe = 4'b0001 << offset;
                data_request.data   = {4{exec_data.wb_result[7:0]}};
            end
            MEM_SH: begin
                data_request.strobe = offset[1] ? 4'b1100 : 4'b0011;
                data_request.data   = {2{exec_data.wb_result[15:0]}};
            end
            MEM_SW: begin
                data_request.strobe = 4'b1111;
                data_request.data   = exec_data.wb_result;
            end
            default: begin
                data_request.strobe = 4'b0000;
                data_request.data   = exec_data.wb_result;
            end
        endcase
    end

    // ========================================
    // sequencing and writeback
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state <= go_memory ? ST_WAIT : ST_HOLD;
                    end
                end
                ST_WAIT: begin
                    if (resp_valid) begin
                        state <= wb_ready ? ST_IDLE : ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (wb_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // a skipped access gets its record right away, a reply only when stalled.
    always_ff @(posedge clk) begin
        if (take) begin
            op_offset           <= offset;
            op_code             <= exec_data.mem_op;
            op_rd               <= exec_data.rd;
            held_rec.data       <= '0;
            held_rec.rd         <= exec_data.rd;
            held_rec.is_load    <= is_load_op(exec_data.mem_op);
            held_rec.misaligned <= misaligned;
        end else if (state == ST_WAIT && resp_valid) begin
            held_rec <= reply_rec;
        end
    end

    rv32_load_extend u_load_extend (
        .mem_op      (op_code),
        .byte_offset (op_offset),
        .word        (data_response.data),
        .data        (load_data)
    );

    always_comb begin
        reply_rec.data       = load_data;
        reply_rec.rd         = op_rd;
        reply_rec.is_load    = is_load_op(op_code);
        reply_rec.misaligned = 1'b0;
    end

    assign wb_valid = (state == ST_HOLD) || (state == ST_WAIT && resp_valid);
    assign wb_data  = (state == ST_HOLD) ? held_rec : reply_rec;

    // a reply belongs to the one open access.
    assert property (@(posedge clk) disable iff (rst) resp_valid |-> state == ST_WAIT);

    assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !(exec_data.mem_addr[0] && exec_data.mem_op inside
                        {MEM_LH, MEM_LHU, MEM_SH, MEM_LW, MEM_SW})
                   && !(exec_data.mem_addr[1] && exec_data.mem_op inside {MEM_LW, MEM_SW}));

endmodule

/* source/rv32_data_memory.sv */
`timescale 1ns/1ps

module rv32_data_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  rv32_pkg::memory_request_t  request,
    output logic                       resp_valid,
    output rv32_pkg::memory_response_t response
);

    import rv32_pkg::*;

    localparam int INDEX_W = $clog2(MEM_WORDS);

    logic [XLEN-1:0]    mem [MEM_WORDS] = '{default: '0};
    logic [INDEX_W-1:0] index;
    logic               accept;

    assign req_ready = 1'b1;
    assign accept    = req_valid && req_ready;

    // word address modulo the depth, depth being a power of two.
    assign index = request.addr[INDEX_W+1:2];

    // ========================================
    // storage
    // ========================================

    always_ff @(posedge clk) begin
        if (accept && request.write) begin
            for (int lane = 0; lane < XLEN / 8; lane++) begin
                if (request.strobe[lane]) begin
                    mem[index][8*lane +: 8] <= request.data[8*lane +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            response.data <= mem[index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;
        end
    end

    // the store lane logic upstream always enables at least one byte.
    assert property (@(posedge clk) disable iff (rst)
        req_valid && request.write |-> request.strobe != 4'b0000);

endmodule

/* source/rv32_pipe_reg.sv */
`timescale 1ns/1ps

module rv32_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t held;

    // free when empty or drained in this same cycle.
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = held;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held <= in_data;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* source/rv32_mem_stage.sv */
`timescale 1ns/1ps

module rv32_mem_stage #(
    parameter int MEM_WORDS = 256
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        exec_valid,
    output logic                        exec_ready,
    input  rv32_pkg::exec_buffer_data_t exec_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    output rv32_pkg::writeback_t        out_data
);

    import rv32_pkg::*;

    logic              buf_valid;
    logic              buf_ready;
    exec_buffer_data_t buf_data;
    logic              req_valid;
    logic              req_ready;
    memory_request_t   data_request;
    logic              resp_valid;
    memory_response_t  data_response;
    logic              wb_valid;
    logic              wb_ready;
    writeback_t        wb_data;

    // ========================================
    // input buffer
    // ========================================

    rv32_pipe_reg #(.payload_t(exec_buffer_data_t)) u_exec_buffer (
        .clk(clk), .rst(rst),
        .in_valid(exec_valid), .in_ready(exec_ready), .in_data(exec_data),
        .out_valid(buf_valid), .out_ready(buf_ready), .out_data(buf_data)
    );

    rv32_load_store_unit u_lsu (
        .clk(clk), .rst(rst),
        .exec_valid(buf_valid), .exec_ready(buf_ready), .exec_data(buf_data),
        .req_valid(req_valid), .req_ready(req_ready), .data_request(data_request),
        .resp_valid(resp_valid), .data_response(data_response),
        .wb_valid(wb_valid), .wb_ready(wb_ready), .wb_data(wb_data)
    );

    rv32_data_memory #(.MEM_WORDS(MEM_WORDS)) u_dmem (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .request(data_request),
        .resp_valid(resp_valid), .response(data_response)
    );

    // writeback register.
    rv32_pipe_reg #(.payload_t(writeback_t)) u_wb_reg (
        .clk(clk), .rst(rst),
        .in_valid(wb_valid), .in_ready(wb_ready), .in_data(wb_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
    );

endmodule

/* verif/rv32_mem_stage_tb.sv */
`timescale 1ns/1ps

module rv32_mem_stage_tb;

    import rv32_pkg::*;

    localparam int RESET_CYCLES = 8;

    logic              clk = 1'b0;
    logic              rst;
    logic              exec_valid;
    logic              exec_ready;
    exec_buffer_data_t exec_data;
    logic              out_valid;
    logic              out_ready;
    writeback_t        out_data;

    logic [7:0]  ref_mem [1024] = '{default: '0};
    writeback_t  exp_q[$];
    writeback_t  got_q[$];
    logic [31:0] rand_state = 32'd41115;
    logic        ready_pattern [256];
    int          n_issued = 0;
    int          cycles = 0;
    logic        saw_stall;
    logic        stream_done;

    rv32_mem_stage #(.MEM_WORDS(256)) dut0 (
        .clk(clk), .rst(rst),
        .exec_valid(exec_valid), .exec_ready(exec_ready), .exec_data(exec_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
    );

    always #4 clk = ~clk;

    // results leave the stage in order, so a queue is enough.
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            got_q.push_back(out_data);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > RESET_CYCLES + 50 * (n_issued + 1)) begin
            $display("timeout: no result after %0d cycles with %0d operations issued",
                     cycles, n_issued);
            $display("Regression failed");
            $fatal(1, "watchdog expired");
        end
    end

    // ========================================
    // reference model and checks
    // ========================================

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic writeback_t model_apply(input exec_buffer_data_t item);
        writeback_t rec;
        logic [9:0] base;
        logic       half_op;
        logic       word_op;
        rec         = '0;
        rec.rd      = item.rd;
        rec.is_load = item.mem_op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
        half_op     = item.mem_op inside {MEM_LH, MEM_LHU, MEM_SH};
        word_op     = item.mem_op inside {MEM_LW, MEM_SW};
        if ((half_op && item.mem_addr[0]) || (word_op && item.mem_addr[1:0] != 2'b00)) begin
            rec.misaligned = 1'b1;
            return rec;
        end
        base = item.mem_addr[9:0];
        case (item.mem_op)
            MEM_SB: ref_mem[base] = item.wb_result[7:0];
            MEM_SH: begin
                ref_mem[base]     = item.wb_result[7:0];
                ref_mem[base + 1] = item.wb_result[15:8];
            end
            MEM_SW: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[base + i] = item.wb_result[8*i +: 8];
                end
            end
            MEM_LB:  rec.data = {{24{ref_mem[base][7]}}, ref_mem[base]};
            MEM_LBU: rec.data = {24'b0, ref_mem[base]};
            MEM_LH:  rec.data = {{16{ref_mem[base + 1][7]}}, ref_mem[base + 1], ref_mem[base]};
            MEM_LHU: rec.data = {16'b0, ref_mem[base + 1], ref_mem[base]};
            MEM_LW: begin
                rec.data = {ref_mem[base + 3], ref_mem[base + 2],
                            ref_mem[base + 1], ref_mem[base]};
            end
            default: ;
        endcase
        return rec;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "check failed");
    endtask

    task automatic report_field_mismatch(input string test, input string field,
                                         input logic [31:0] got, input logic [31:0] exp);
        $display("ERR t=%0t %s out_data.%s got %h expected %h", $time, test, field, got, exp);
        $display("Regression failed");
        $fatal(1, "writeback mismatch");
    endtask

    task automatic check_writeback(input string test, input writeback_t got,
                                   input writeback_t exp);
        if (got.data !== exp.data) report_field_mismatch(test, "data", got.data, exp.data);
        if (got.rd !== exp.rd) report_field_mismatch(test, "rd", got.rd, exp.rd);
        if (got.is_load !== exp.is_load) begin
            report_field_mismatch(test, "is_load", got.is_load, exp.is_load);
        end
        if (got.misaligned !== exp.misaligned) begin
            report_field_mismatch(test, "misaligned", got.misaligned, exp.misaligned);
        end
    endtask

    // ========================================
    // stimulus
    // ========================================

    // starts and ends on a falling edge.
    task automatic issue(input logic [31:0] addr, input mem_op_t op,
                         input logic [31:0] value, input logic [4:0] rd);
        exec_buffer_data_t item;
        item.mem_addr  = addr;
        item.mem_op    = op;
        item.wb_result = value;
        item.rd        = rd;
        exec_valid     = 1'b1;
        exec_data      = item;
        @(posedge clk);
        while (!exec_ready) @(posedge clk);
        exp_q.push_back(model_apply(item));
        n_issued++;
        @(negedge clk);
        exec_valid = 1'b0;
    endtask

    task automatic drain_and_check(input string test);
        writeback_t got;
        writeback_t exp;
        while (got_q.size() < exp_q.size()) @(posedge clk);
        while (exp_q.size() > 0) begin
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            check_writeback(test, got, exp);
        end
        @(negedge clk);
    endtask

    task automatic word_roundtrip();
        issue(32'h10, MEM_SW, 32'hDEAD_BEEF, 5'd3);
        issue(32'h10, MEM_LW, 32'h0, 5'd7);
        issue(32'h24, MEM_SW, 32'h1234_5678, 5'd0);
        issue(32'h24, MEM_LW, 32'h0, 5'd31);
        drain_and_check("word_roundtrip");
    endtask

    task automatic byte_half_lanes();
        issue(32'h40, MEM_SW, 32'h0123_4567, 5'd1);
        for (int k = 0; k < 4; k++) begin
            issue(32'h40 + k, MEM_SB, k[0] ? 32'h35 : 32'hC0 + k, 5'd2);
            issue(32'h40, MEM_LW, 32'h0, 5'd3);
        end
        for (int k = 0; k < 4; k++) begin
            issue(32'h40 + k, MEM_LB, 32'h0, 5'(k + 4));
            issue(32'h40 + k, MEM_LBU, 32'h0, 5'(k + 8));
        end
        issue(32'h44, MEM_SW, 32'hA5A5_A5A5, 5'd1);
        issue(32'h44, MEM_SH, 32'h0000_8001, 5'd2);
        issue(32'h46, MEM_SH, 32'h0000_7FFE, 5'd2);
        issue(32'h44, MEM_LW, 32'h0, 5'd12);
        for (int k = 0; k < 4; k += 2) begin
            issue(32'h44 + k, MEM_LH, 32'h0, 5'(k + 13));
            issue(32'h44 + k, MEM_LHU, 32'h0, 5'(k + 17));
        end
        drain_and_check("byte_half_lanes");
    endtask

    task automatic misaligned_access();
        issue(32'h80, MEM_SW, 32'hCAFE_F00D, 5'd1);
        issue(32'h81, MEM_LH, 32'h0, 5'd2);
        issue(32'h83, MEM_LHU, 32'h0, 5'd3);
        issue(32'h81, MEM_SH, 32'h0000_1111, 5'd4);
        issue(32'h82, MEM_LW, 32'h0, 5'd5);
        issue(32'h81, MEM_SW, 32'h2222_2222, 5'd6);
        issue(32'h83, MEM_SW, 32'h3333_3333, 5'd7);
        issue(32'h80, MEM_LW, 32'h0, 5'd8);
        drain_and_check("misaligned");
    endtask

    task automatic backpressure_order();
        saw_stall = 1'b0;
        fork
            begin
                for (int k = 0; k < 8; k++) begin
                    issue(32'h100 + 4 * (k % 3), k[0] ? MEM_LW : MEM_SW,
                          32'h5A00_0000 + k, 5'(k + 1));
                end
            end
            begin
                out_ready = 1'b0;
                repeat (20) begin
                    @(posedge clk);
                    if (!exec_ready) saw_stall = 1'b1;
                end
                @(negedge clk);
                out_ready = 1'b1;
            end
        join
        if (!saw_stall) stop_with_error("exec_ready stayed high while out_ready was held low");
        drain_and_check("backpressure");
    endtask

    task automatic random_stream();
        logic [31:0] r;
        for (int i = 0; i < 256; i++) begin
            r = lcg_next();
            ready_pattern[i] = r[30] | r[29];
        end
        stream_done = 1'b0;
        fork
            begin
                logic [31:0] sel;
                logic [31:0] addr;
                logic [31:0] value;
                logic [4:0]  rd;
                for (int i = 0; i < 200; i++) begin
                    sel   = lcg_next() >> 16;
                    addr  = lcg_next() & 32'h3F;
                    value = lcg_next();
                    rd    = 5'(lcg_next() >> 20);
                    issue(addr, mem_op_t'(4'(sel % 9)), value, rd);
                end
                stream_done = 1'b1;
            end
            begin
                int k;
                k = 0;
                while (!stream_done) begin
                    @(negedge clk);
                    out_ready = ready_pattern[k % 256];
                    k++;
                end
            end
        join
        out_ready = 1'b1;
        drain_and_check("random_stream");
    endtask

    initial begin
        rst        = 1'b1;
        exec_valid = 1'b0;
        exec_data  = '0;
        // held low so exec_ready shows the buffer's own state.
        out_ready  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (!exec_ready || out_valid) stop_with_error("stage is not empty after reset");
        out_ready = 1'b1;
        word_roundtrip();
        byte_half_lanes();
        misaligned_access();
        backpressure_order();
        random_stream();
        repeat (10) @(posedge clk);
        if (got_q.size() != 0) begin
            $display("%0d results arrived that no operation asked for", got_q.size());
            $display("Regression failed");
            $fatal(1, "extra results");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* rv32_mem_stage.f */
common/rv32_pkg.sv
load_store/rv32_load_extend.sv
load_store/rv32_load_store_unit.sv
source/rv32_data_memory.sv
source/rv32_pipe_reg.sv
source/rv32_mem_stage.sv
verif/rv32_mem_stage_tb.sv
